// ==== hw/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

`define NUM_BANKS 4
`define BANKS_LEN 2
`define NUM_WAYS 4
`define WAYS_LEN 2
`define NUM_SETS_PER_BANK 4
`define SETS_LEN 2
`define BLOCK_SIZE 4
`define BLOCK_OFF_BIT_LEN 2
`define BYTE_OFF_BIT_LEN 2
`define UUID_SIZE 4

`define NUM_BLOCKS_PER_BANK (`NUM_SETS_PER_BANK * `NUM_WAYS)
`define TREE_BITS (`NUM_WAYS - 1)
`define INDEX_LEN (`BANKS_LEN + `SETS_LEN)
`define TAG_LEN (32 - `INDEX_LEN - `BLOCK_OFF_BIT_LEN - `BYTE_OFF_BIT_LEN)

`endif

// ==== hw/cache_types_pkg.sv ====
`include "cache_defines.svh"

package cache_types_pkg;

    // the bank number sits in the low bits of the index.
    typedef struct packed {
        logic [`TAG_LEN-1:0]           tag;
        logic [`INDEX_LEN-1:0]         index;
        logic [`BLOCK_OFF_BIT_LEN-1:0] block_offset;
        logic [`BYTE_OFF_BIT_LEN-1:0]  byte_offset;
    } addr_t;

    typedef struct packed {
        logic                         valid;
        logic                         dirty;
        logic [`TAG_LEN-1:0]          tag;
        logic [`BLOCK_SIZE-1:0][31:0] block;
    } cache_frame;

    typedef cache_frame [`NUM_WAYS-1:0] cache_set;

    typedef struct packed {
        logic [`TREE_BITS-1:0] tree;
    } psuedo_lru_frame;

    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } mem_op_t;

    typedef struct packed {
        addr_t                 addr;
        mem_op_t               op;
        logic [31:0]           store_value;
        logic [`UUID_SIZE-1:0] uuid;
    } in_mem_instr;

    typedef struct packed {
        logic                          valid;
        logic [`UUID_SIZE-1:0]         uuid;
        addr_t                         block_addr;
        logic [`BLOCK_OFF_BIT_LEN-1:0] word_offset;
        mem_op_t                       op;
        logic [`BLOCK_SIZE-1:0]        write_status;
        logic [`BLOCK_SIZE-1:0][31:0]  write_block;
    } mshr_reg;

    typedef enum logic [2:0] {
        START,
        BLOCK_PULL,
        VICTIM_EJECT,
        FINISH,
        FLUSH,
        WRITEBACK,
        HALT
    } bank_fsm_states;

endpackage

// ==== hw/bank_req_if.sv ====
`timescale 1ns/1ns
`include "cache_defines.svh"

interface bank_req_if;
    import cache_types_pkg::*;

    logic                  instr_valid;
    in_mem_instr           mem_instr;
    mshr_reg               mshr_entry;
    logic                  halt;
    logic                  hit;
    logic [31:0]           data_out;
    logic                  uuid_ready;
    logic [`UUID_SIZE-1:0] uuid_out;
    logic [31:0]           miss_data;
    logic                  flushed;

    modport scheduler (
        output instr_valid, mem_instr, mshr_entry, halt,
        input  hit, data_out, uuid_ready, uuid_out, miss_data, flushed
    );

    modport bank (
        input  instr_valid, mem_instr, mshr_entry, halt,
        output hit, data_out, uuid_ready, uuid_out, miss_data, flushed
    );

endinterface

// ==== hw/ram_port_if.sv ====
`timescale 1ns/1ns

interface ram_port_if;
    import cache_types_pkg::*;

    logic        ren;
    logic        wen;
    addr_t       addr;
    logic [31:0] store;
    logic [31:0] rdata;
    logic        complete;

    modport requester (output ren, wen, addr, store, input rdata, complete);

    modport memory (input ren, wen, addr, store, output rdata, complete);

endinterface

// ==== hw/request_scheduler.sv ====
`timescale 1ns/1ns
`include "cache_defines.svh"

module request_scheduler (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       req_valid,
    input  cache_types_pkg::addr_t     req_addr,
    input  cache_types_pkg::mem_op_t   req_op,
    input  logic [31:0]                req_data,
    input  logic [`UUID_SIZE-1:0]      req_uuid,
    input  logic                       halt,
    bank_req_if.scheduler              banks [`NUM_BANKS],
    output logic                       resp_valid,
    output logic [`UUID_SIZE-1:0]      resp_uuid,
    output logic [31:0]                resp_data,
    output logic                       miss_valid,
    output logic [`UUID_SIZE-1:0]      miss_uuid,
    output logic [31:0]                miss_data,
    output logic [`NUM_BANKS-1:0]      bank_busy,
    output logic                       flushed
);
    import cache_types_pkg::*;

    logic [`BANKS_LEN-1:0] sel;
    logic [`BANKS_LEN-1:0] win;
    logic                  issue;
    logic                  halt_q;
    logic [`NUM_BANKS-1:0] hit_v, ready_v, flushed_v, pend_v, cand, flush_mask;
    logic [31:0]           data_v [`NUM_BANKS];
    logic [31:0]           mdata_v [`NUM_BANKS];
    logic [31:0]           pend_data [`NUM_BANKS];
    logic [`UUID_SIZE-1:0] uuid_v [`NUM_BANKS];
    logic [`UUID_SIZE-1:0] pend_uuid [`NUM_BANKS];
    mshr_reg               mshr_q [`NUM_BANKS];
    mshr_reg               new_entry;

    assign sel = req_addr.index[`BANKS_LEN-1:0];
    assign issue = req_valid && !bank_busy[sel];

    for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_link
        assign banks[b].instr_valid = issue && (sel == `BANKS_LEN'(b));
        assign banks[b].mem_instr = '{addr: req_addr, op: req_op,
                                      store_value: req_data, uuid: req_uuid};
        assign banks[b].mshr_entry = mshr_q[b];
        assign banks[b].halt = halt_q && !flush_mask[b];
        assign hit_v[b] = banks[b].hit;
        assign data_v[b] = banks[b].data_out;
        assign ready_v[b] = banks[b].uuid_ready;
        assign uuid_v[b] = banks[b].uuid_out;
        assign mdata_v[b] = banks[b].miss_data;
        assign flushed_v[b] = banks[b].flushed;
        assign bank_busy[b] = mshr_q[b].valid || banks[b].halt;
    end

    // a store miss carries its word into the MSHR so the fill can merge it.
    always_comb begin
        new_entry = '0;
        new_entry.valid = 1'b1;
        new_entry.uuid = req_uuid;
        new_entry.block_addr = req_addr;
        new_entry.block_addr.block_offset = '0;
        new_entry.block_addr.byte_offset = '0;
        new_entry.word_offset = req_addr.block_offset;
        new_entry.op = req_op;
        if (req_op == OP_STORE) begin
            new_entry.write_status[req_addr.block_offset] = 1'b1;
            new_entry.write_block[req_addr.block_offset] = req_data;
        end
    end

    // lowest bank with a finished miss goes out first.
    always_comb begin
        cand = pend_v | ready_v;
        win = '0;
        for (int b = `NUM_BANKS - 1; b >= 0; b--) begin
            if (cand[b]) begin
                win = `BANKS_LEN'(b);
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            resp_valid <= 1'b0;
            miss_valid <= 1'b0;
            flushed <= 1'b0;
            halt_q <= 1'b0;
            flush_mask <= '0;
            pend_v <= '0;
            for (int b = 0; b < `NUM_BANKS; b++) begin
                mshr_q[b] <= '0;
            end
        end else begin
            resp_valid <= issue && hit_v[sel];
            miss_valid <= |cand;
            for (int b = 0; b < `NUM_BANKS; b++) begin
                if (ready_v[b]) begin
                    mshr_q[b].valid <= 1'b0;
                end else if (issue && !hit_v[sel] && sel == `BANKS_LEN'(b)) begin
                    mshr_q[b] <= new_entry;
                end
                pend_v[b] <= cand[b] && (win != `BANKS_LEN'(b));
            end
            flushed <= 1'b0;
            if (halt) begin
                halt_q <= 1'b1;
            end
            if (halt_q) begin
                if (&(flush_mask | flushed_v)) begin
                    flushed <= 1'b1;
                    halt_q <= 1'b0;
                    flush_mask <= '0;
                end else begin
                    flush_mask <= flush_mask | flushed_v;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        resp_uuid <= req_uuid;
        resp_data <= data_v[sel];
        miss_uuid <= pend_v[win] ? pend_uuid[win] : uuid_v[win];
        miss_data <= pend_v[win] ? pend_data[win] : mdata_v[win];
        for (int b = 0; b < `NUM_BANKS; b++) begin
            if (ready_v[b]) begin
                pend_uuid[b] <= uuid_v[b];
                pend_data[b] <= mdata_v[b];
            end
        end
    end

endmodule

// ==== hw/cache_bank.sv ====
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_bank (
    input  logic          CLK,
    input  logic          nRST,
    bank_req_if.bank      req,
    ram_port_if.requester ram,
    output logic          bank_busy
);
    import cache_types_pkg::*;

    cache_set [`NUM_SETS_PER_BANK-1:0]        sets_q, sets_d;
    psuedo_lru_frame [`NUM_SETS_PER_BANK-1:0] lru_q, lru_d;
    bank_fsm_states                           state, next_state;
    mshr_reg                                  mshr;
    cache_frame                               fill_buf, victim_buf, fl_frame;
    logic [`BLOCK_OFF_BIT_LEN-1:0]            count;
    logic                                     count_step, last_word;
    logic [`SETS_LEN-1:0]                     req_set, mshr_set, v_set, fl_set;
    logic [`WAYS_LEN-1:0]                     hit_way, match_way, pick_way, v_way, fl_way;
    logic [`BANKS_LEN-1:0]                    own_bank;
    logic                                     match, match_q;
    logic [`SETS_LEN+`WAYS_LEN-1:0]           flush_ptr;

    // point every node on the path away from the touched way.
    function automatic logic [`TREE_BITS-1:0] lru_touch(input logic [`TREE_BITS-1:0] tree,
                                                        input logic [`WAYS_LEN-1:0] way);
        int node;
        node = 0;
        for (int lvl = 0; lvl < `WAYS_LEN; lvl++) begin
            tree[node] = ~way[`WAYS_LEN-1-lvl];
            node = way[`WAYS_LEN-1-lvl] ? 2 * node + 2 : 2 * node + 1;
        end
        return tree;
    endfunction

    function automatic logic [`WAYS_LEN-1:0] lru_victim(input logic [`TREE_BITS-1:0] tree);
        int node;
        logic [`WAYS_LEN-1:0] way;
        node = 0;
        for (int lvl = 0; lvl < `WAYS_LEN; lvl++) begin
            way[`WAYS_LEN-1-lvl] = tree[node];
            node = tree[node] ? 2 * node + 2 : 2 * node + 1;
        end
        return way;
    endfunction

    assign mshr = req.mshr_entry;
    assign req_set = req.mem_instr.addr.index[`INDEX_LEN-1:`BANKS_LEN];
    assign mshr_set = mshr.block_addr.index[`INDEX_LEN-1:`BANKS_LEN];
    assign fl_set = flush_ptr[`SETS_LEN-1:0];
    assign fl_way = flush_ptr[`SETS_LEN+`WAYS_LEN-1:`SETS_LEN];
    assign fl_frame = sets_q[fl_set][fl_way];
    assign last_word = (count == `BLOCK_SIZE - 1);
    assign pick_way = match ? match_way : lru_victim(lru_q[mshr_set].tree);

    assign req.uuid_ready = (state == FINISH);
    assign req.uuid_out = mshr.uuid;
    assign req.miss_data = fill_buf.block[mshr.word_offset];
    assign req.flushed = (state == HALT);
    assign bank_busy = mshr.valid || (state inside {FLUSH, WRITEBACK, HALT});

    always_comb begin
        sets_d = sets_q;
        req.hit = 1'b0;
        req.data_out = '0;
        hit_way = '0;
        if (req.instr_valid) begin
            for (int w = 0; w < `NUM_WAYS; w++) begin
                if (!req.hit && sets_q[req_set][w].valid &&
                    sets_q[req_set][w].tag == req.mem_instr.addr.tag) begin
                    req.hit = 1'b1;
                    hit_way = `WAYS_LEN'(w);
                end
            end
            if (req.hit && req.mem_instr.op == OP_STORE) begin
                sets_d[req_set][hit_way].block[req.mem_instr.addr.block_offset] =
                    req.mem_instr.store_value;
                sets_d[req_set][hit_way].dirty = 1'b1;
            end else if (req.hit) begin
                req.data_out = sets_q[req_set][hit_way].block[req.mem_instr.addr.block_offset];
            end
        end
        if (state == FINISH) begin
            sets_d[v_set][v_way] = fill_buf;
        end else if (state == WRITEBACK && count_step && last_word) begin
            sets_d[fl_set][fl_way].valid = 1'b0;
            sets_d[fl_set][fl_way].dirty = 1'b0;
        end
    end

    // the missed block may already be resident, then it is reused in place.
    always_comb begin
        match = 1'b0;
        match_way = '0;
        for (int w = 0; w < `NUM_WAYS; w++) begin
            if (sets_q[mshr_set][w].valid && sets_q[mshr_set][w].tag == mshr.block_addr.tag) begin
                match = 1'b1;
                match_way = `WAYS_LEN'(w);
            end
        end
    end

    always_comb begin
        lru_d = lru_q;
        if (req.hit) begin
            lru_d[req_set].tree = lru_touch(lru_q[req_set].tree, hit_way);
        end else if (state == FINISH) begin
            lru_d[v_set].tree = lru_touch(lru_q[v_set].tree, v_way);
        end
    end

    always_comb begin
        case (state)
            BLOCK_PULL: count_step = mshr.write_status[count] || match_q || ram.complete;
            VICTIM_EJECT, WRITEBACK: count_step = ram.complete;
            default: count_step = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            START: begin
                if (mshr.valid) begin
                    next_state = BLOCK_PULL;
                end else if (req.halt) begin
                    next_state = FLUSH;
                end
            end
            BLOCK_PULL: begin
                if (count_step && last_word) begin
                    next_state = (victim_buf.valid && victim_buf.dirty && !match_q) ?
                                 VICTIM_EJECT : FINISH;
                end
            end
            VICTIM_EJECT: if (count_step && last_word) next_state = FINISH;
            FINISH: next_state = START;
            FLUSH: begin
                if (fl_frame.valid && fl_frame.dirty) begin
                    next_state = WRITEBACK;
                end else if (&flush_ptr) begin
                    next_state = HALT;
                end
            end
            WRITEBACK: if (count_step && last_word) next_state = FLUSH;
            default: next_state = START;
        endcase
    end

    always_comb begin
        ram.ren = 1'b0;
        ram.wen = 1'b0;
        ram.addr = '0;
        ram.store = '0;
        case (state)
            BLOCK_PULL: begin
                ram.ren = !match_q && !mshr.write_status[count];
                ram.addr = '{tag: mshr.block_addr.tag, index: mshr.block_addr.index,
                             block_offset: count, byte_offset: '0};
            end
            VICTIM_EJECT: begin
                ram.wen = 1'b1;
                ram.addr = '{tag: victim_buf.tag, index: {v_set, own_bank},
                             block_offset: count, byte_offset: '0};
                ram.store = victim_buf.block[count];
            end
            WRITEBACK: begin
                ram.wen = 1'b1;
                ram.addr = '{tag: fl_frame.tag, index: {fl_set, own_bank},
                             block_offset: count, byte_offset: '0};
                ram.store = fl_frame.block[count];
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= START;
            sets_q <= '0;
            lru_q <= '0;
            count <= '0;
            flush_ptr <= '0;
            own_bank <= '0;
        end else begin
            state <= next_state;
            sets_q <= sets_d;
            lru_q <= lru_d;
            if (count_step) begin
                count <= count + 1'b1;
            end
            if (state == FLUSH && next_state == FLUSH) begin
                flush_ptr <= flush_ptr + 1'b1;
            end else if (state == HALT) begin
                flush_ptr <= '0;
            end
            // frames keep only the tag, so the bank learns its own number here.
            if (req.instr_valid) begin
                own_bank <= req.mem_instr.addr.index[`BANKS_LEN-1:0];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == START && mshr.valid) begin
            v_set <= mshr_set;
            v_way <= pick_way;
            victim_buf <= sets_q[mshr_set][pick_way];
            match_q <= match;
            fill_buf.valid <= 1'b1;
            fill_buf.tag <= mshr.block_addr.tag;
            fill_buf.dirty <= (mshr.op == OP_STORE) || (match && sets_q[mshr_set][match_way].dirty);
        end else if (state == BLOCK_PULL) begin
            if (mshr.write_status[count]) begin
                fill_buf.block[count] <= mshr.write_block[count];
            end else if (match_q) begin
                fill_buf.block[count] <= victim_buf.block[count];
            end else if (ram.complete) begin
                fill_buf.block[count] <= ram.rdata;
            end
        end
    end

endmodule

// ==== hw/ram_arbiter.sv ====
`timescale 1ns/1ns
`include "cache_defines.svh"

module ram_arbiter (
    input  logic          CLK,
    input  logic          nRST,
    ram_port_if.memory    bank_ports [`NUM_BANKS],
    ram_port_if.requester mem
);
    import cache_types_pkg::*;

    logic [`NUM_BANKS-1:0] ren_v, wen_v, want;
    addr_t                 addr_v [`NUM_BANKS];
    logic [31:0]           store_v [`NUM_BANKS];
    logic [`BANKS_LEN-1:0] grant, pick, cur;
    logic                  locked, keep, found, active;

    for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_port
        assign ren_v[b] = bank_ports[b].ren;
        assign wen_v[b] = bank_ports[b].wen;
        assign addr_v[b] = bank_ports[b].addr;
        assign store_v[b] = bank_ports[b].store;
        assign bank_ports[b].complete = active && (cur == `BANKS_LEN'(b)) && mem.complete;
        assign bank_ports[b].rdata = (active && cur == `BANKS_LEN'(b)) ? mem.rdata : '0;
    end

    assign want = ren_v | wen_v;

    // search starts at the bank after the last winner.
    always_comb begin
        logic [`BANKS_LEN-1:0] idx;
        found = 1'b0;
        pick = grant;
        for (int i = 1; i <= `NUM_BANKS; i++) begin
            idx = grant + `BANKS_LEN'(i);
            if (!found && want[idx]) begin
                found = 1'b1;
                pick = idx;
            end
        end
    end

    assign keep = locked && want[grant];
    assign cur = keep ? grant : pick;
    assign active = keep || found;

    assign mem.ren = active && ren_v[cur];
    assign mem.wen = active && wen_v[cur];
    assign mem.addr = addr_v[cur];
    assign mem.store = store_v[cur];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            locked <= 1'b0;
            grant <= '0;
        end else begin
            locked <= active;
            if (active) begin
                grant <= cur;
            end
        end
    end

endmodule

// ==== hw/banked_cache.sv ====
`timescale 1ns/1ns
`include "cache_defines.svh"

module banked_cache (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     req_valid,
    input  cache_types_pkg::addr_t   req_addr,
    input  cache_types_pkg::mem_op_t req_op,
    input  logic [31:0]              req_data,
    input  logic [`UUID_SIZE-1:0]    req_uuid,
    input  logic                     halt,
    output logic                     resp_valid,
    output logic [`UUID_SIZE-1:0]    resp_uuid,
    output logic [31:0]              resp_data,
    output logic                     miss_valid,
    output logic [`UUID_SIZE-1:0]    miss_uuid,
    output logic [31:0]              miss_data,
    output logic [`NUM_BANKS-1:0]    bank_busy,
    output logic                     flushed,
    output logic                     ram_ren,
    output logic                     ram_wen,
    output cache_types_pkg::addr_t   ram_addr,
    output logic [31:0]              ram_store,
    input  logic [31:0]              ram_rdata,
    input  logic                     ram_complete
);

    bank_req_if bank_links [`NUM_BANKS] ();
    ram_port_if bank_ram [`NUM_BANKS] ();
    ram_port_if mem_ram ();

    request_scheduler u_request_scheduler (
        .CLK        (CLK),
        .nRST       (nRST),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_op     (req_op),
        .req_data   (req_data),
        .req_uuid   (req_uuid),
        .halt       (halt),
        .banks      (bank_links),
        .resp_valid (resp_valid),
        .resp_uuid  (resp_uuid),
        .resp_data  (resp_data),
        .miss_valid (miss_valid),
        .miss_uuid  (miss_uuid),
        .miss_data  (miss_data),
        .bank_busy  (bank_busy),
        .flushed    (flushed)
    );

    // the requester sees the scheduler's busy view, which already covers each bank.
    for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
        cache_bank u_cache_bank (
            .CLK       (CLK),
            .nRST      (nRST),
            .req       (bank_links[b]),
            .ram       (bank_ram[b]),
            .bank_busy ()
        );
    end

    ram_arbiter u_ram_arbiter (
        .CLK        (CLK),
        .nRST       (nRST),
        .bank_ports (bank_ram),
        .mem        (mem_ram)
    );

    assign ram_ren = mem_ram.ren;
    assign ram_wen = mem_ram.wen;
    assign ram_addr = mem_ram.addr;
    assign ram_store = mem_ram.store;
    assign mem_ram.rdata = ram_rdata;
    assign mem_ram.complete = ram_complete;

endmodule

// ==== test/ram_model.sv ====
`timescale 1ns/1ns
`include "cache_defines.svh"

module ram_model (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   ren,
    input  logic                   wen,
    input  cache_types_pkg::addr_t addr,
    input  logic [31:0]            store,
    output logic [31:0]            rdata,
    output logic                   complete
);
    import cache_types_pkg::*;

    localparam int LATENCY = 3;
    localparam int DEPTH = 512;

    logic [31:0] words [DEPTH];
    logic [31:0] flat;
    logic [8:0]  idx;
    int          cnt;

    // every word starts from a pattern that depends on all of its address bits.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            words[i] = 32'h1357_2468 ^ (32'(i) * 32'h9e37_79b1);
        end
    end

    assign flat = addr;
    assign idx = flat[10:2];

    // a request held for LATENCY cycles completes for exactly one cycle.
    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt <= 0;
            complete <= 1'b0;
            rdata <= '0;
        end else begin
            complete <= 1'b0;
            if ((ren || wen) && !complete) begin
                if (cnt == LATENCY - 1) begin
                    cnt <= 0;
                    complete <= 1'b1;
                    if (wen) begin
                        words[idx] <= store;
                    end else begin
                        rdata <= words[idx];
                    end
                end else begin
                    cnt <= cnt + 1;
                end
            end else begin
                cnt <= 0;
            end
        end
    end

    function automatic logic [31:0] peek(input addr_t a);
        logic [31:0] word_addr;
        word_addr = a;
        return words[word_addr[10:2]];
    endfunction

endmodule

// ==== test/tb_banked_cache.sv ====
`timescale 1ns/1ns
`include "cache_defines.svh"

module tb_banked_cache;
    import cache_types_pkg::*;

    localparam int STIM_CYCLES = 600;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int FLUSH_TIMEOUT = 6000;
    localparam int MEM_WORDS = 512;
    localparam int NUM_UUIDS = 1 << `UUID_SIZE;

    logic                  CLK;
    logic                  nRST;
    logic                  req_valid;
    addr_t                 req_addr;
    mem_op_t               req_op;
    logic [31:0]           req_data;
    logic [`UUID_SIZE-1:0] req_uuid;
    logic                  halt;
    logic                  resp_valid;
    logic [`UUID_SIZE-1:0] resp_uuid;
    logic [31:0]           resp_data;
    logic                  miss_valid;
    logic [`UUID_SIZE-1:0] miss_uuid;
    logic [31:0]           miss_data;
    logic [`NUM_BANKS-1:0] bank_busy;
    logic                  flushed;
    logic                  ram_ren;
    logic                  ram_wen;
    addr_t                 ram_addr;
    logic [31:0]           ram_store;
    logic [31:0]           ram_rdata;
    logic                  ram_complete;

    integer                seed;
    int                    value_errors;
    int                    protocol_errors;
    int                    outstanding;
    int                    flush_pulses;
    logic [31:0]           model [MEM_WORDS];
    logic                  touched [MEM_WORDS];
    logic                  pending [NUM_UUIDS];
    mem_op_t               exp_op [NUM_UUIDS];
    logic [31:0]           exp_data [NUM_UUIDS];
    logic                  prev_valid;
    logic [`UUID_SIZE-1:0] prev_uuid;
    logic [`BANKS_LEN-1:0] prev_bank;
    logic [`UUID_SIZE-1:0] next_uuid;

    banked_cache u_banked_cache (.*);

    ram_model u_ram_model (
        .CLK      (CLK),
        .nRST     (nRST),
        .ren      (ram_ren),
        .wen      (ram_wen),
        .addr     (ram_addr),
        .store    (ram_store),
        .rdata    (ram_rdata),
        .complete (ram_complete)
    );

    always #4 CLK = ~CLK;

    function automatic logic [8:0] word_index(input addr_t a);
        logic [31:0] flat;
        flat = a;
        return flat[10:2];
    endfunction

    task automatic check_resp(input logic [`UUID_SIZE-1:0] got_uuid, exp_uuid,
                              input logic [31:0] got_data, exp_word, input mem_op_t op);
        if (got_uuid !== exp_uuid) begin
            $display("CHECK FAILED at %0t: resp_uuid is %0d, expected %0d",
                     $time, got_uuid, exp_uuid);
            value_errors++;
        end else if (op == OP_LOAD && got_data !== exp_word) begin
            $display("CHECK FAILED at %0t: resp_data for uuid %0d is %h, expected %h",
                     $time, got_uuid, got_data, exp_word);
            value_errors++;
        end
    endtask

    task automatic check_miss(input logic [`UUID_SIZE-1:0] got_uuid, input logic [31:0] got_data);
        if (!pending[got_uuid]) begin
            $display("ERROR at %0t: miss_valid for uuid %0d, which has no request outstanding",
                     $time, got_uuid);
            protocol_errors++;
        end else begin
            if (exp_op[got_uuid] == OP_LOAD && got_data !== exp_data[got_uuid]) begin
                $display("CHECK FAILED at %0t: miss_data for uuid %0d is %h, expected %h",
                         $time, got_uuid, got_data, exp_data[got_uuid]);
                value_errors++;
            end
            pending[got_uuid] = 1'b0;
            outstanding--;
        end
    endtask

    task automatic check_mem(input addr_t addr, input logic [31:0] exp_word);
        logic [31:0] got;
        got = u_ram_model.peek(addr);
        if (got !== exp_word) begin
            $display("CHECK FAILED at %0t: RAM word at %h is %h, expected %h",
                     $time, addr, got, exp_word);
            value_errors++;
        end
    endtask

    // a request from the last cycle either hit or made its bank busy.
    task automatic observe_outputs();
        if (prev_valid) begin
            if (resp_valid) begin
                check_resp(resp_uuid, prev_uuid, resp_data, exp_data[prev_uuid], exp_op[prev_uuid]);
                pending[prev_uuid] = 1'b0;
                outstanding--;
            end else if (!bank_busy[prev_bank]) begin
                $display("ERROR at %0t: uuid %0d got neither a hit response nor a busy bank",
                         $time, prev_uuid);
                protocol_errors++;
                pending[prev_uuid] = 1'b0;
                outstanding--;
            end
        end else if (resp_valid) begin
            $display("ERROR at %0t: resp_valid with no request in the previous cycle", $time);
            protocol_errors++;
        end
        if (miss_valid) begin
            check_miss(miss_uuid, miss_data);
        end
        if (flushed) begin
            flush_pulses++;
        end
    endtask

    task automatic drive_idle();
        req_valid = 1'b0;
        halt = 1'b0;
        prev_valid = 1'b0;
    endtask

    task automatic drive_random();
        logic [31:0]           pick;
        logic [`BANKS_LEN-1:0] bank;
        logic [8:0]            idx;
        int                    tries;
        pick = $random(seed);
        req_data = $random(seed);
        req_valid = 1'b0;
        prev_valid = 1'b0;
        bank = pick[7:6];
        tries = 0;
        while (pending[next_uuid] && tries < NUM_UUIDS) begin
            next_uuid++;
            tries++;
        end
        // eight tags over two sets per bank keep the ways under pressure.
        if (pick[1:0] != 2'b00 && !bank_busy[bank] && !pending[next_uuid]) begin
            req_addr = '0;
            req_addr.tag[2:0] = pick[5:3];
            req_addr.index = {`SETS_LEN'(pick[8]), bank};
            req_addr.block_offset = pick[10:9];
            req_op = pick[2] ? OP_STORE : OP_LOAD;
            req_uuid = next_uuid;
            idx = word_index(req_addr);
            if (req_op == OP_STORE) begin
                model[idx] = req_data;
            end
            exp_op[next_uuid] = req_op;
            exp_data[next_uuid] = model[idx];
            pending[next_uuid] = 1'b1;
            touched[idx] = 1'b1;
            outstanding++;
            req_valid = 1'b1;
            prev_valid = 1'b1;
            prev_uuid = next_uuid;
            prev_bank = bank;
            next_uuid++;
        end
    endtask

    initial begin
        int waited;
        seed = 32'h9c359cd6;
        CLK = 1'b0;
        nRST = 1'b0;
        req_valid = 1'b0;
        req_addr = '0;
        req_op = OP_LOAD;
        req_data = '0;
        req_uuid = '0;
        halt = 1'b0;
        value_errors = 0;
        protocol_errors = 0;
        outstanding = 0;
        flush_pulses = 0;
        prev_valid = 1'b0;
        prev_uuid = '0;
        prev_bank = '0;
        next_uuid = '0;
        for (int u = 0; u < NUM_UUIDS; u++) begin
            pending[u] = 1'b0;
        end
        repeat (8) @(posedge CLK);
        #1;
        nRST = 1'b1;

        for (int i = 0; i < MEM_WORDS; i++) begin
            model[i] = u_ram_model.peek(addr_t'(32'(i) << 2));
            touched[i] = 1'b0;
        end
        if (resp_valid || miss_valid || flushed || ram_ren || ram_wen || bank_busy != '0) begin
            $display("ERROR at %0t: outputs are not all low after reset", $time);
            protocol_errors++;
        end

        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            @(posedge CLK);
            #1;
            observe_outputs();
            drive_random();
        end

        waited = 0;
        while ((outstanding != 0 || prev_valid) && waited < DRAIN_TIMEOUT) begin
            @(posedge CLK);
            #1;
            observe_outputs();
            drive_idle();
            waited++;
        end
        if (outstanding != 0) begin
            $display("ERROR at %0t: timed out with %0d requests still without a response",
                     $time, outstanding);
            protocol_errors++;
        end

        @(posedge CLK);
        #1;
        observe_outputs();
        drive_idle();
        halt = 1'b1;
        waited = 0;
        while (flush_pulses == 0 && waited < FLUSH_TIMEOUT) begin
            @(posedge CLK);
            #1;
            observe_outputs();
            drive_idle();
            waited++;
        end
        if (flush_pulses == 0) begin
            $display("ERROR at %0t: timed out waiting for flushed after halt", $time);
            protocol_errors++;
        end
        // a second pulse would show up within a few cycles.
        repeat (20) begin
            @(posedge CLK);
            #1;
            observe_outputs();
        end
        if (flush_pulses > 1) begin
            $display("ERROR at %0t: flushed pulsed %0d times for one halt", $time, flush_pulses);
            protocol_errors++;
        end

        for (int i = 0; i < MEM_WORDS; i++) begin
            if (touched[i]) begin
                check_mem(addr_t'(32'(i) << 2), model[i]);
            end
        end

        $display("Summary: %0d value errors, %0d protocol errors", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/cache_types_pkg.sv
hw/bank_req_if.sv
hw/ram_port_if.sv
hw/request_scheduler.sv
hw/cache_bank.sv
hw/ram_arbiter.sv
hw/banked_cache.sv
test/ram_model.sv
test/tb_banked_cache.sv
